//--- tb.f
sched_pkg.sv
cmd_intake.sv
cmd_ram.sv
row_writer.sv
row_scanner.sv
cmd_scheduler.sv
tb_cmd_scheduler.sv

//--- tb_cmd_scheduler.sv
`timescale 1ns/1ps

module tb_cmd_scheduler;

	localparam int ADDR_W = 3;
	localparam int ROWS   = 1 << ADDR_W; // 8 rows keep every scan short

	typedef enum logic [1:0] {
		st_write,   // new command on spi_wr
		st_request, // req_comm with a next command expected
		st_jump,    // cur_time reload and sys_time_update
		st_fault    // req_comm with no future command left
	} step_kind_e;

	typedef struct packed {
		step_kind_e       kind;
		sched_pkg::time_t cmd_time; // start time of a written command
		sched_pkg::time_t new_time; // cur_time after a jump
	} step_t;

	logic             CLK = 1'b0;
	logic             rst_n;
	sched_pkg::time_t cur_time;
	logic             spi_wr;
	sched_pkg::cmd_t  cmd_in;
	logic             sys_time_update;
	logic             req_comm;
	logic             data_wr;
	sched_pkg::cmd_t  cmd_out;
	logic             search_fault;
	sched_pkg::busy_t busy_rows;

	step_t            steps [$];         // stimulus table
	sched_pkg::cmd_t  model_mem [ROWS];  // reference copy of the rows
	sched_pkg::cmd_t  model_out = '0;    // command the DUT should present
	int               model_exec = 0;    // row deleted by the next request
	int               err_value = 0;     // wrong output values
	int               err_other = 0;     // protocol and table problems
	int               cycle_cnt = 0;
	int               cycle_limit = 100000; // replaced once the table is built

	cmd_scheduler #(.ADDR_W(ADDR_W)) cmd_scheduler_i (
		.CLK             (CLK),
		.rst_n           (rst_n),
		.cur_time        (cur_time),
		.spi_wr          (spi_wr),
		.cmd_in          (cmd_in),
		.sys_time_update (sys_time_update),
		.req_comm        (req_comm),
		.data_wr         (data_wr),
		.cmd_out         (cmd_out),
		.search_fault    (search_fault),
		.busy_rows       (busy_rows)
	);

	always #5 CLK = ~CLK; // 10 ns period

	// ------------------------------------------------------------
	// watchdog
	// ------------------------------------------------------------
	always @(posedge CLK)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit)
		begin
			$display("timeout: the DUT gave no result within %0d cycles", cycle_limit);
			print_counts();
			$display("Finished with errors");
			$finish;
		end
	end

	// ------------------------------------------------------------
	// compare tasks
	// ------------------------------------------------------------
	task automatic check_cmd(input string name, input sched_pkg::cmd_t got,
		input sched_pkg::cmd_t exp);
		if (got !== exp)
		begin
			err_value++;
			$display("FAILED %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			err_value++;
			$display("FAILED %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_busy(input string name, input sched_pkg::busy_t got,
		input sched_pkg::busy_t exp);
		if (got !== exp)
		begin
			err_value++;
			$display("FAILED %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic print_counts();
		$display("value errors: %0d, other errors: %0d", err_value, err_other);
	endtask

	// ------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------
	function automatic int free_row();
		int r;
		int i;
		r = -1;
		for (i = ROWS - 1; i >= 0; i--)
			if (model_mem[i].time_start == sched_pkg::EMPTY_TIME)
				r = i; // lowest empty row survives
		return r;
	endfunction

	function automatic int earliest_row(input sched_pkg::time_t now);
		int best;
		int i;
		best = -1;
		for (i = 0; i < ROWS; i++)
			if (model_mem[i].time_start > now)
				if (best < 0 || model_mem[i].time_start < model_mem[best].time_start)
					best = i; // strict compare keeps the lower row on a tie
		return best;
	endfunction

	function automatic sched_pkg::busy_t used_rows();
		sched_pkg::busy_t n;
		int i;
		n = '0;
		for (i = 0; i < ROWS; i++)
			if (model_mem[i].time_start != sched_pkg::EMPTY_TIME)
				n = n + 1'b1;
		return n;
	endfunction

	function automatic sched_pkg::cmd_t random_cmd(input sched_pkg::time_t t);
		sched_pkg::cmd_t c;
		c.time_start   = t;
		c.freq         = {16'($urandom), $urandom};
		c.freq_step    = {16'($urandom), $urandom};
		c.freq_rate    = $urandom;
		c.n_impulse    = 16'($urandom);
		c.type_impulse = 2'($urandom);
		c.interval_ti  = $urandom;
		c.interval_tp  = $urandom;
		c.tblank1      = $urandom;
		c.tblank2      = $urandom;
		return c;
	endfunction

	// ------------------------------------------------------------
	// stimulus helpers
	// ------------------------------------------------------------
	task automatic next_cycle();
		@(negedge CLK);
		cur_time = cur_time + 1; // system time runs every cycle
	endtask

	task automatic add_step(input step_kind_e kind, input sched_pkg::time_t cmd_time,
		input sched_pkg::time_t new_time);
		step_t s;
		s.kind     = kind;
		s.cmd_time = cmd_time;
		s.new_time = new_time;
		steps.push_back(s);
	endtask

	task automatic run_step(input step_t s, input int n);
		sched_pkg::cmd_t c;
		logic            sf_before;
		logic            exp_fault;
		int              row;
		sf_before = search_fault;
		case (s.kind)
			st_write:
			begin
				c   = random_cmd(s.cmd_time);
				row = free_row();
				if (row < 0)
				begin
					err_other++;
					$display("step %0d writes into a full memory", n);
				end
				else
					model_mem[row] = c;
				cmd_in = c;
				spi_wr = 1'b1;
				next_cycle();
				spi_wr = 1'b0;
			end
			st_jump:
			begin
				cur_time        = s.new_time;
				sys_time_update = 1'b1;
				next_cycle();
				sys_time_update = 1'b0;
			end
			default: // request or expected fault
			begin
				model_mem[model_exec] = '0; // presented row is deleted
				req_comm              = 1'b1;
				next_cycle();
				req_comm              = 1'b0;
			end
		endcase
		row       = earliest_row(cur_time);
		exp_fault = (row < 0);
		if (!exp_fault)
		begin
			model_out  = model_mem[row];
			model_exec = row;
		end
		if (s.kind == st_fault && !exp_fault)
		begin
			err_other++;
			$display("step %0d expects a fault but the model finds a command", n);
		end
		// result is a data_wr pulse or a fresh search_fault
		while (!(data_wr || (search_fault && !sf_before)))
			next_cycle();
		check_bit("search_fault", search_fault, exp_fault);
		check_bit("data_wr", data_wr, !exp_fault);
		check_cmd("cmd_out", cmd_out, model_out);
		check_busy("busy_rows", busy_rows, used_rows());
		next_cycle();
		check_bit("data_wr", data_wr, 1'b0); // pulse lasts one cycle
		next_cycle();
	endtask

	// ------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------
	initial
	begin
		int i;
		rst_n           = 1'b0;
		cur_time        = 64'd1000;
		spi_wr          = 1'b0;
		cmd_in          = '0;
		sys_time_update = 1'b0;
		req_comm        = 1'b0;
		void'($urandom(62));
		for (i = 0; i < ROWS; i++)
			model_mem[i] = '0;

		add_step(st_fault,   64'd0,     64'd0);     // request with empty memory
		add_step(st_write,   64'd50000, 64'd0);     // row 0
		add_step(st_write,   64'd30000, 64'd0);     // row 1 becomes the earliest
		add_step(st_write,   64'd70000, 64'd0);     // row 2
		add_step(st_request, 64'd0,     64'd0);     // drop row 1
		add_step(st_request, 64'd0,     64'd0);     // drop row 0
		add_step(st_fault,   64'd0,     64'd0);     // drop row 2 and leave the memory empty
		add_step(st_write,   64'd30000, 64'd0);     // row 0
		add_step(st_write,   64'd30000, 64'd0);     // row 1 ties with row 0
		add_step(st_request, 64'd0,     64'd0);     // drop row 0
		add_step(st_write,   64'd30000, 64'd0);     // row 0 reused and wins the tie
		add_step(st_write,   64'd50000, 64'd0);
		add_step(st_write,   64'd90000, 64'd0);
		add_step(st_write,   64'd60000, 64'd0);
		add_step(st_jump,    64'd0,     64'd40000); // rows 0 and 1 now in the past
		add_step(st_request, 64'd0,     64'd0);
		add_step(st_jump,    64'd0,     64'd75000);
		add_step(st_write,   64'd80000, 64'd0);     // fills the gap at row 2
		add_step(st_request, 64'd0,     64'd0);
		cycle_limit = steps.size() * 100 + 200;

		repeat (3)
			next_cycle();
		rst_n = 1'b1;
		next_cycle();
		check_bit("data_wr", data_wr, 1'b0);
		check_bit("search_fault", search_fault, 1'b0);
		check_busy("busy_rows", busy_rows, '0);
		check_cmd("cmd_out", cmd_out, '0);

		for (i = 0; i < steps.size(); i++)
			run_step(steps[i], i);

		print_counts();
		if (err_value + err_other == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

//--- cmd_scheduler.sv
`timescale 1ns/1ps

module cmd_scheduler #(
	parameter int ADDR_W = 6 // memory holds 2**ADDR_W rows
) (
	input  logic              CLK,
	input  logic              rst_n,
	input  sched_pkg::time_t  cur_time,
	input  logic              spi_wr,
	input  sched_pkg::cmd_t   cmd_in,
	input  logic              sys_time_update,
	input  logic              req_comm,
	output logic              data_wr,
	output sched_pkg::cmd_t   cmd_out,
	output logic              search_fault,
	output sched_pkg::busy_t  busy_rows
);

	sched_pkg::cmd_t     cmd_latched; // intake to writer
	sched_pkg::pend_t    pend;        // intake to scanner
	sched_pkg::pend_t    take;        // scanner to intake
	sched_pkg::wr_req_t  wr_req;      // scanner to writer
	logic                writer_busy;
	logic                wr_en;       // memory write port
	logic [ADDR_W-1:0]   wr_addr;
	sched_pkg::cmd_t     wr_data;
	logic [ADDR_W-1:0]   rd_addr;     // memory read port
	sched_pkg::cmd_t     rd_data;

	cmd_intake intake_i (
		.CLK             (CLK),
		.rst_n           (rst_n),
		.spi_wr          (spi_wr),
		.cmd_in          (cmd_in),
		.sys_time_update (sys_time_update),
		.req_comm        (req_comm),
		.take            (take),
		.cmd_latched     (cmd_latched),
		.pend            (pend)
	);

	row_scanner #(.ADDR_W(ADDR_W)) scanner_i (
		.CLK          (CLK),
		.rst_n        (rst_n),
		.cur_time     (cur_time),
		.pend         (pend),
		.writer_busy  (writer_busy),
		.rd_data      (rd_data),
		.take         (take),
		.wr_req       (wr_req),
		.rd_addr      (rd_addr),
		.data_wr      (data_wr),
		.cmd_out      (cmd_out),
		.search_fault (search_fault),
		.busy_rows    (busy_rows)
	);

	row_writer #(.ADDR_W(ADDR_W)) writer_i (
		.CLK         (CLK),
		.rst_n       (rst_n),
		.wr_req      (wr_req),
		.cmd_latched (cmd_latched),
		.wr_en       (wr_en),
		.wr_addr     (wr_addr),
		.wr_data     (wr_data),
		.writer_busy (writer_busy)
	);

	cmd_ram #(.ADDR_W(ADDR_W)) ram_i (
		.CLK     (CLK),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

endmodule

//--- row_scanner.sv
`timescale 1ns/1ps

module row_scanner #(
	parameter int ADDR_W = 6
) (
	input  logic                 CLK,
	input  logic                 rst_n,
	input  sched_pkg::time_t     cur_time,     // running system time
	input  sched_pkg::pend_t     pend,         // pending jobs from the intake
	input  logic                 writer_busy,
	input  sched_pkg::cmd_t      rd_data,      // memory row, two cycles after rd_addr
	output sched_pkg::pend_t     take,         // job accept pulses
	output sched_pkg::wr_req_t   wr_req,       // write or clear strobe
	output logic [ADDR_W-1:0]    rd_addr,
	output logic                 data_wr,      // new command pulse for the sync block
	output sched_pkg::cmd_t      cmd_out,      // presented command
	output logic                 search_fault, // no future command stored
	output sched_pkg::busy_t     busy_rows     // non-empty rows at the last pass
);

	localparam logic [ADDR_W-1:0] LAST_ROW = '1;

	sched_pkg::scan_state_e state;
	sched_pkg::time_t       cur_q;     // registered current time
	logic                   iss;       // rd_addr holds an address to read
	logic                   v_d1;      // read pipeline valid bits
	logic                   v_d2;
	logic [ADDR_W-1:0]      a_d1;      // read pipeline addresses
	logic [ADDR_W-1:0]      a_d2;      // row that rd_data belongs to
	logic                   flush_cnt; // two flush cycles
	logic                   found;     // a future command has been seen
	sched_pkg::busy_t       busy_cnt;  // non-empty rows in this pass
	sched_pkg::cmd_t        best_cmd;  // earliest future command so far
	logic [ADDR_W-1:0]      best_addr;
	logic [ADDR_W-1:0]      exec_row;  // row of the presented command
	logic                   scan_hit;  // rd_data is part of a find_next pass
	logic                   better;    // rd_data beats the current best

	assign scan_hit = v_d2 && (state == sched_pkg::sc_find_next || state == sched_pkg::sc_flush);
	assign better   = scan_hit && (rd_data.time_start > cur_q)
	                  && (!found || rd_data.time_start < best_cmd.time_start); // ties keep lower row

	// ----------------------------------------------------------
	// read pipeline tracking
	// ----------------------------------------------------------
	always_ff @(posedge CLK)
	begin
		cur_q <= cur_time;
		a_d1  <= rd_addr;
		a_d2  <= a_d1;
		if (better)
		begin
			best_cmd  <= rd_data;
			best_addr <= a_d2;
		end
	end

	always_ff @(posedge CLK)
	begin
		if (!rst_n)
		begin
			v_d1     <= 1'b0;
			v_d2     <= 1'b0;
			found    <= 1'b0;
			busy_cnt <= '0;
		end
		else
		begin
			v_d1 <= iss;
			v_d2 <= v_d1;
			if (state == sched_pkg::sc_idle || state == sched_pkg::sc_write_wait)
			begin
				found    <= 1'b0; // fresh pass
				busy_cnt <= '0;
			end
			else if (scan_hit)
			begin
				if (rd_data.time_start != sched_pkg::EMPTY_TIME)
					busy_cnt <= busy_cnt + 1'b1;
				if (better)
					found <= 1'b1;
			end
		end
	end

	// ----------------------------------------------------------
	// scan FSM
	// ----------------------------------------------------------
	always_ff @(posedge CLK)
	begin
		if (!rst_n)
		begin
			state        <= sched_pkg::sc_idle;
			iss          <= 1'b0;
			rd_addr      <= '0;
			flush_cnt    <= 1'b0;
			take         <= '0;
			wr_req       <= '0;
			data_wr      <= 1'b0;
			search_fault <= 1'b0;
			busy_rows    <= '0;
			exec_row     <= '0;
			cmd_out      <= '0;
		end
		else
		begin
			take    <= '0; // strobes last one cycle
			wr_req  <= '0;
			data_wr <= 1'b0;
			case (state)
				sched_pkg::sc_idle:
				begin
					rd_addr <= '0;
					if (!writer_busy && pend.alloc)
					begin
						take.alloc <= 1'b1;
						iss        <= 1'b1;
						state      <= sched_pkg::sc_find_free;
					end
					else if (!writer_busy && pend.exec_done)
					begin
						take.exec_done <= 1'b1;
						take.resched   <= pend.resched; // the same pass covers it
						wr_req         <= '{write: 1'b0, clear: 1'b1, addr: 8'(exec_row)};
						state          <= sched_pkg::sc_write_wait;
					end
					else if (!writer_busy && pend.resched)
					begin
						take.resched <= 1'b1;
						iss          <= 1'b1;
						state        <= sched_pkg::sc_find_next;
					end
				end
				sched_pkg::sc_find_free:
				begin
					if (iss)
					begin
						if (rd_addr == LAST_ROW)
							iss <= 1'b0; // all addresses issued
						else
							rd_addr <= rd_addr + 1'b1;
					end
					if (v_d2 && rd_data.time_start == sched_pkg::EMPTY_TIME)
					begin
						iss    <= 1'b0; // first free row wins
						wr_req <= '{write: 1'b1, clear: 1'b0, addr: 8'(a_d2)};
						state  <= sched_pkg::sc_write_wait;
					end
					else if (v_d2 && a_d2 == LAST_ROW)
						state <= sched_pkg::sc_idle; // memory full, command dropped
				end
				sched_pkg::sc_write_wait:
				begin
					rd_addr <= '0;
					if (!wr_req.write && !wr_req.clear && !writer_busy)
					begin
						iss   <= 1'b1; // row is settled, search again
						state <= sched_pkg::sc_find_next;
					end
				end
				sched_pkg::sc_find_next:
				begin
					if (rd_addr == LAST_ROW)
					begin
						iss       <= 1'b0;
						flush_cnt <= 1'b0;
						state     <= sched_pkg::sc_flush;
					end
					else
						rd_addr <= rd_addr + 1'b1;
				end
				sched_pkg::sc_flush:
				begin
					flush_cnt <= 1'b1;
					if (flush_cnt)
						state <= sched_pkg::sc_load; // last row compared this cycle
				end
				default: // load
				begin
					busy_rows <= busy_cnt;
					if (found)
					begin
						cmd_out      <= best_cmd;
						exec_row     <= best_addr; // deleted on the next req_comm
						data_wr      <= 1'b1;
						search_fault <= 1'b0;
					end
					else
						search_fault <= 1'b1;
					state <= sched_pkg::sc_idle;
				end
			endcase
		end
	end

endmodule

//--- row_writer.sv
`timescale 1ns/1ps

module row_writer #(
	parameter int ADDR_W = 6
) (
	input  logic                 CLK,
	input  logic                 rst_n,
	input  sched_pkg::wr_req_t   wr_req,      // one-cycle request from the scanner
	input  sched_pkg::cmd_t      cmd_latched, // command to store on a write
	output logic                 wr_en,
	output logic [ADDR_W-1:0]    wr_addr,
	output sched_pkg::cmd_t      wr_data,
	output logic                 writer_busy  // high while not idle
);

	localparam logic [ADDR_W-1:0] LAST_ROW = '1;

	sched_pkg::write_state_e state;
	logic [ADDR_W-1:0]       row_addr; // target row, also the clear-all counter

	// ----------------------------------------------------------
	// write FSM
	// ----------------------------------------------------------
	always_ff @(posedge CLK)
	begin
		if (!rst_n)
		begin
			state    <= sched_pkg::wr_clear_all; // wipe the memory after reset
			row_addr <= '0;
		end
		else
		begin
			case (state)
				sched_pkg::wr_clear_all:
				begin
					row_addr <= row_addr + 1'b1; // one row per cycle
					if (row_addr == LAST_ROW)
						state <= sched_pkg::wr_idle;
				end
				sched_pkg::wr_clear_row:
					state <= sched_pkg::wr_idle; // single cycle delete
				sched_pkg::wr_write_row:
					state <= sched_pkg::wr_idle; // single cycle store
				default:
				begin
					if (wr_req.clear)
					begin
						state    <= sched_pkg::wr_clear_row;
						row_addr <= wr_req.addr[ADDR_W-1:0];
					end
					else if (wr_req.write)
					begin
						state    <= sched_pkg::wr_write_row;
						row_addr <= wr_req.addr[ADDR_W-1:0];
					end
				end
			endcase
		end
	end

	// ----------------------------------------------------------
	// memory write port
	// ----------------------------------------------------------
	assign writer_busy = (state != sched_pkg::wr_idle);
	assign wr_en       = writer_busy; // every non-idle state writes one row
	assign wr_addr     = row_addr;

	always_comb
	begin
		if (state == sched_pkg::wr_write_row)
			wr_data = cmd_latched;
		else
			wr_data = '0; // clear and clear-all store zeros
	end

endmodule

//--- cmd_ram.sv
`timescale 1ns/1ps

module cmd_ram #(
	parameter int ADDR_W = 6
) (
	input  logic                CLK,
	input  logic                wr_en,
	input  logic [ADDR_W-1:0]   wr_addr,
	input  sched_pkg::cmd_t     wr_data,
	input  logic [ADDR_W-1:0]   rd_addr,
	output sched_pkg::cmd_t     rd_data  // row at rd_addr, two cycles later
);

	localparam int DEPTH = 1 << ADDR_W;

	sched_pkg::cmd_t mem [DEPTH]; // command rows
	sched_pkg::cmd_t rd_q;        // array output register

	always_ff @(posedge CLK)
	begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// two register read path
	always_ff @(posedge CLK)
	begin
		rd_q    <= mem[rd_addr];
		rd_data <= rd_q; // output register
	end

endmodule

//--- cmd_intake.sv
`timescale 1ns/1ps

module cmd_intake (
	input  logic              CLK,
	input  logic              rst_n,
	input  logic              spi_wr,          // mcu write strobe, level
	input  sched_pkg::cmd_t   cmd_in,          // command fields from the mcu port
	input  logic              sys_time_update, // time reload strobe
	input  logic              req_comm,        // sync block asks for the next command
	input  sched_pkg::pend_t  take,            // job accepted by the scanner
	output sched_pkg::cmd_t   cmd_latched,     // last received command
	output sched_pkg::pend_t  pend             // jobs not yet accepted
);

	logic spi_wr_q;   // previous strobe levels
	logic time_upd_q;
	logic req_comm_q;

	sched_pkg::pend_t rise; // one-cycle rising edge flags

	// ----------------------------------------------------------
	// edge detection
	// ----------------------------------------------------------
	assign rise.alloc     = spi_wr & ~spi_wr_q;
	assign rise.resched   = sys_time_update & ~time_upd_q;
	assign rise.exec_done = req_comm & ~req_comm_q;

	always_ff @(posedge CLK)
	begin
		if (!rst_n)
		begin
			spi_wr_q   <= 1'b0;
			time_upd_q <= 1'b0;
			req_comm_q <= 1'b0;
			pend       <= '0;
		end
		else
		begin
			spi_wr_q   <= spi_wr;
			time_upd_q <= sys_time_update;
			req_comm_q <= req_comm;
			pend       <= rise | (pend & ~take); // fresh edge beats a take
		end
	end

	// ----------------------------------------------------------
	// command holding register
	// ----------------------------------------------------------
	always_ff @(posedge CLK)
	begin
		if (rise.alloc)
			cmd_latched <= cmd_in; // stays put while a free row is searched
	end

endmodule

//--- sched_pkg.sv
package sched_pkg;

	// ----------------------------------------------------------
	// time and command word
	// ----------------------------------------------------------
	typedef logic [63:0] time_t; // system time in clock ticks

	typedef struct packed {
		time_t       time_start;  // execution time, zero marks a free row
		logic [47:0] freq;        // start frequency
		logic [47:0] freq_step;   // frequency step
		logic [31:0] freq_rate;   // step rate
		logic [15:0] n_impulse;   // number of pulses
		logic [1:0]  type_impulse; // pulse type, low bits of the mcu byte
		logic [31:0] interval_ti; // pulse length
		logic [31:0] interval_tp; // pulse period
		logic [31:0] tblank1;     // first blanking interval
		logic [31:0] tblank2;     // second blanking interval
	} cmd_t;

	localparam time_t EMPTY_TIME = '0; // start time of an unused row

	localparam int BUSY_W = 16;
	typedef logic [BUSY_W-1:0] busy_t; // occupied row count

	// ----------------------------------------------------------
	// job flags and write requests
	// ----------------------------------------------------------
	typedef struct packed {
		logic alloc;     // new command waiting for a row
		logic resched;   // system time was reloaded
		logic exec_done; // presented command has been taken
	} pend_t;

	typedef struct packed {
		logic       write; // store the latched command
		logic       clear; // zero the row
		logic [7:0] addr;  // target row, low bits used
	} wr_req_t;

	typedef enum logic [1:0] {
		wr_clear_all,
		wr_clear_row,
		wr_write_row,
		wr_idle
	} write_state_e;

	typedef enum logic [2:0] {
		sc_idle,
		sc_find_free,
		sc_write_wait,
		sc_find_next,
		sc_load,
		sc_flush
	} scan_state_e;

endpackage
